//--- hdl/adc_pkg.sv
`default_nettype none

package adc_pkg;

   // raw ADC word straight off the converter pins
   localparam int adc_width = 12;

   typedef logic [adc_width-1:0] adc_sample_t;

   // single-shot trigger bookkeeping
   typedef enum logic {
      TRIG_READY = 1'b0,  // may fire
      TRIG_SPENT = 1'b1   // fired since last arming
   } trig_state_e;

endpackage

`default_nettype wire

//--- hdl/monitor_pkg.sv
`default_nettype none

package monitor_pkg;

   localparam int freq_width = 32;
   localparam int gain_width = 8;

   // what the two front panel LEDs show
   typedef enum logic [1:0] {
      LED_STATUS = 2'b00,  // armed / capture active
      LED_TIMERS = 2'b01,  // heartbeat bits
      LED_WINDOW = 2'b10,  // window strobe stretch / flash
      LED_EXTCLK = 2'b11   // target clock change
   } led_mode_e;

   // target clock edges per measurement window
   typedef logic [freq_width-1:0] freq_count_t;

   // amplifier gain as a PWM duty out of 256
   typedef logic [gain_width-1:0] gain_t;

endpackage

`default_nettype wire

//--- hdl/adc_sample_source.sv
`timescale 1ns/1ps
`default_nettype none

module adc_sample_source (
   input  wire                  clk_usb,
   input  wire                  reset,
   input  wire                  data_source_select_i,  // 1 = ADC, 0 = test counter
   input  wire adc_pkg::adc_sample_t adc_data_i,
   output adc_pkg::adc_sample_t sample_o
);
   import adc_pkg::*;

   adc_sample_t test_count;
   adc_sample_t sample_pre;

   // free-running ramp, wraps at 4096
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         test_count <= '0;
      end
      else begin
         test_count <= test_count + adc_sample_t'(1);
      end
   end

   // first stage picks the source, second stage matches the
   // delay the capture buffer expects
   always_ff @(posedge clk_usb) begin
      sample_pre <= data_source_select_i ? adc_data_i : test_count;
      sample_o   <= sample_pre;
   end

endmodule

`default_nettype wire

//--- hdl/adc_level_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module adc_level_trigger (
   input  wire                  clk_usb,
   input  wire                  reset,
   input  wire adc_pkg::adc_sample_t sample_i,
   input  wire adc_pkg::adc_sample_t trigger_level_i,  // msb set = fire above, clear = below
   input  wire                  adc_trigger_active_i,
   input  wire                  armed_and_ready_i,
   output logic                 trigger_adc_o
);
   import adc_pkg::*;

   trig_state_e state_q;
   logic        arm_q;      // arming, one cycle late
   logic        level_hit;
   logic        fire;

   always_comb begin
      if (trigger_level_i[adc_width-1]) begin
         level_hit = sample_i > trigger_level_i;
      end
      else begin
         level_hit = sample_i < trigger_level_i;
      end
      fire = (state_q == TRIG_READY) && adc_trigger_active_i && arm_q && level_hit;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state_q       <= TRIG_READY;
         arm_q         <= 1'b0;
         trigger_adc_o <= 1'b0;
      end
      else begin
         arm_q         <= armed_and_ready_i;
         trigger_adc_o <= fire;
         if (fire) begin
            state_q <= TRIG_SPENT;
         end
         else if (armed_and_ready_i && !arm_q) begin
            state_q <= TRIG_READY;  // rearm on rising edge only
         end
      end
   end

   // one pulse, never a pair
   a_single_pulse: assert property (
      @(posedge clk_usb) disable iff (reset)
      trigger_adc_o |=> !trigger_adc_o
   );

   // once spent, nothing fires until the next arming edge
   a_no_fire_spent: assert property (
      @(posedge clk_usb) disable iff (reset)
      (state_q == TRIG_SPENT) |=> !trigger_adc_o
   );

endmodule

`default_nettype wire

//--- hdl/extclk_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module extclk_monitor (
   input  wire                  clk_usb,
   input  wire                  reset,
   input  wire                  ext_clk_i,   // slow target clock, async to clk_usb
   input  wire                  window_i,    // one-cycle measurement strobe
   input  wire monitor_pkg::freq_count_t extclk_limit_i,
   input  wire                  extclk_monitor_disable_i,
   output monitor_pkg::freq_count_t frequency_o,
   output logic                 change_o
);
   import monitor_pkg::*;

   logic        ext_meta;
   logic        ext_sync;
   logic        ext_prev;
   logic        ext_edge;
   freq_count_t edge_count;
   freq_count_t count_delta;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_meta <= 1'b0;
         ext_sync <= 1'b0;
         ext_prev <= 1'b0;
      end
      else begin
         ext_meta <= ext_clk_i;
         ext_sync <= ext_meta;
         ext_prev <= ext_sync;
      end
   end

   assign ext_edge = ext_sync && !ext_prev;

   // distance between this window and the last one, either direction
   assign count_delta = (edge_count > frequency_o) ? edge_count - frequency_o
                                                   : frequency_o - edge_count;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         edge_count  <= '0;
         frequency_o <= '0;
      end
      else if (window_i) begin
         frequency_o <= edge_count;
         edge_count  <= freq_count_t'(ext_edge);  // edge in strobe cycle opens new window
      end
      else if (ext_edge) begin
         edge_count <= edge_count + freq_count_t'(1);
      end
   end

   // sticky until disabled
   always_ff @(posedge clk_usb) begin
      if (reset || extclk_monitor_disable_i) begin
         change_o <= 1'b0;
      end
      else if (window_i && (frequency_o != '0) && (count_delta > extclk_limit_i)) begin
         change_o <= 1'b1;
      end
   end

   a_disable_clears: assert property (
      @(posedge clk_usb) disable iff (reset)
      extclk_monitor_disable_i |=> !change_o
   );

endmodule

`default_nettype wire

//--- hdl/status_indicators.sv
`timescale 1ns/1ps
`default_nettype none

module status_indicators #(
   parameter int p_timer_width = 26
) (
   input  wire                  clk_usb,
   input  wire                  reset,
   input  wire monitor_pkg::led_mode_e led_select_i,
   input  wire                  armed_i,
   input  wire                  capture_active_i,
   input  wire                  extclk_change_i,
   input  wire monitor_pkg::gain_t gain_i,
   output logic                 window_o,         // one pulse per measurement window
   output logic                 flash_pattern_o,
   output logic                 led_armed_o,
   output logic                 led_capture_o,
   output logic                 amp_gain_o
);
   import monitor_pkg::*;

   logic [p_timer_width-1:0] timer_heartbeat;
   logic                     window_bit_q;
   logic                     window_led_q;  // toggles each window so it is visible
   logic [8:0]               pwm_acc;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_heartbeat <= '0;
         window_bit_q    <= 1'b0;
         window_o        <= 1'b0;
         window_led_q    <= 1'b0;
      end
      else begin
         timer_heartbeat <= timer_heartbeat + 1'b1;
         window_bit_q    <= timer_heartbeat[p_timer_width-4];
         window_o        <= timer_heartbeat[p_timer_width-4] && !window_bit_q;
         if (window_o) begin
            window_led_q <= !window_led_q;
         end
      end
   end

   // blinks only in the upper half of the timer span
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         flash_pattern_o <= 1'b0;
      end
      else if (timer_heartbeat[p_timer_width-1]) begin
         flash_pattern_o <= !timer_heartbeat[p_timer_width-3];
      end
   end

   always_comb begin
      led_armed_o   = armed_i;
      led_capture_o = capture_active_i;
      if (extclk_change_i) begin
         // target clock moved, override everything
         led_armed_o   = flash_pattern_o;
         led_capture_o = flash_pattern_o;
      end
      else begin
         case (led_select_i)
            LED_TIMERS: begin
               led_armed_o   = timer_heartbeat[p_timer_width-2];
               led_capture_o = timer_heartbeat[p_timer_width-1];
            end
            LED_WINDOW: begin
               led_armed_o   = window_led_q;
               led_capture_o = flash_pattern_o;
            end
            LED_EXTCLK: begin
               led_armed_o   = timer_heartbeat[p_timer_width-2];  // still alive
               led_capture_o = extclk_change_i;
            end
            default: begin
               led_armed_o   = armed_i;
               led_capture_o = capture_active_i;
            end
         endcase
      end
   end

   // carry out of an 8-bit accumulator gives gain/256 duty
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwm_acc <= '0;
      end
      else begin
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, gain_i};
      end
   end

   assign amp_gain_o = pwm_acc[8];

endmodule

`default_nettype wire

//--- hdl/openadc_front.sv
`timescale 1ns/1ps
`default_nettype none

module openadc_front #(
   parameter int p_timer_width = 26
) (
   input  wire                  clk_usb,
   input  wire                  reset,
   input  wire adc_pkg::adc_sample_t adc_data_i,
   input  wire                  data_source_select_i,
   input  wire adc_pkg::adc_sample_t trigger_level_i,
   input  wire                  adc_trigger_active_i,
   input  wire                  armed_and_ready_i,
   input  wire                  armed_i,
   input  wire                  capture_active_i,
   input  wire                  ext_clk_i,
   input  wire                  extclk_monitor_disable_i,
   input  wire monitor_pkg::freq_count_t extclk_limit_i,
   input  wire monitor_pkg::led_mode_e led_select_i,
   input  wire monitor_pkg::gain_t gain_i,
   output adc_pkg::adc_sample_t adc_data_o,
   output logic                 trigger_adc_o,
   output logic                 freq_measure_o,
   output logic                 flash_pattern_o,
   output logic                 led_armed_o,
   output logic                 led_capture_o,
   output logic                 amp_gain_o,
   output logic                 extclk_change_o,
   output monitor_pkg::freq_count_t extclk_frequency_o
);
   import adc_pkg::*;

   adc_sample_t sample;        // resampled, two cycles behind adc_data_i
   logic        window_pulse;
   logic        extclk_change;

   adc_sample_source u_sample_source (
      .clk_usb              (clk_usb),
      .reset                (reset),
      .data_source_select_i (data_source_select_i),
      .adc_data_i           (adc_data_i),
      .sample_o             (sample)
   );

   adc_level_trigger u_level_trigger (
      .clk_usb              (clk_usb),
      .reset                (reset),
      .sample_i             (sample),
      .trigger_level_i      (trigger_level_i),
      .adc_trigger_active_i (adc_trigger_active_i),
      .armed_and_ready_i    (armed_and_ready_i),
      .trigger_adc_o        (trigger_adc_o)
   );

   extclk_monitor u_extclk_monitor (
      .clk_usb                  (clk_usb),
      .reset                    (reset),
      .ext_clk_i                (ext_clk_i),
      .window_i                 (window_pulse),
      .extclk_limit_i           (extclk_limit_i),
      .extclk_monitor_disable_i (extclk_monitor_disable_i),
      .frequency_o              (extclk_frequency_o),
      .change_o                 (extclk_change)
   );

   status_indicators #(
      .p_timer_width (p_timer_width)
   ) u_status (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .led_select_i     (led_select_i),
      .armed_i          (armed_i),
      .capture_active_i (capture_active_i),
      .extclk_change_i  (extclk_change),
      .gain_i           (gain_i),
      .window_o         (window_pulse),
      .flash_pattern_o  (flash_pattern_o),
      .led_armed_o      (led_armed_o),
      .led_capture_o    (led_capture_o),
      .amp_gain_o       (amp_gain_o)
   );

   assign adc_data_o      = sample;
   assign freq_measure_o  = window_pulse;
   assign extclk_change_o = extclk_change;

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int p_reset_cycles = 10
) (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = !clk_o;  // 4 ns period
   end

   // released on a falling edge, away from the sampling edge
   initial begin
      reset_o = 1'b1;
      repeat (p_reset_cycles) @(posedge clk_o);
      @(negedge clk_o);
      reset_o = 1'b0;
   end

endmodule

`default_nettype wire

//--- bench/openadc_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

module openadc_front_tb;
   import adc_pkg::*;
   import monitor_pkg::*;

   localparam int timer_width = 10;
   localparam int window_len  = 1 << (timer_width - 3);  // cycles per measurement window

   logic        clk_usb;
   logic        reset;
   adc_sample_t adc_data_i;
   logic        data_source_select_i;
   adc_sample_t trigger_level_i;
   logic        adc_trigger_active_i;
   logic        armed_and_ready_i;
   logic        armed_i;
   logic        capture_active_i;
   logic        ext_clk_i = 1'b0;
   logic        extclk_monitor_disable_i;
   freq_count_t extclk_limit_i;
   led_mode_e   led_select_i;
   gain_t       gain_i;
   adc_sample_t adc_data_o;
   logic        trigger_adc_o, freq_measure_o, flash_pattern_o, extclk_change_o;
   logic        led_armed_o, led_capture_o, amp_gain_o;
   freq_count_t extclk_frequency_o;

   int          errors = 0;
   int          checks = 0;
   int          pulse_count = 0;
   int          ext_half = 0;     // target clock half period in cycles (0 stops it)
   int          ext_cnt = 0;
   logic [31:0] lfsr_state = 32'h11a9_776c;

   // reference model state
   adc_sample_t cnt_m, exp_pre, exp_out, last_obs;
   logic        pre_valid = 1'b0;
   logic        out_valid = 1'b0;
   logic        pre_ctr, out_ctr, last_ctr;
   logic        ready_m, arm_q_m, fire_m;
   int          window_gap = 0;   // cycles since the last window pulse
   logic        window_seen = 1'b0;

   tb_clock_gen u_clock (
      .clk_o   (clk_usb),
      .reset_o (reset)
   );

   openadc_front #(
      .p_timer_width (timer_width)
   ) uut (.*);

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // word entering the first resample stage and showing up two cycles later
   function automatic adc_sample_t source_sample(input logic adc_sel, input adc_sample_t adc,
                                                 input adc_sample_t ramp);
      return adc_sel ? adc : ramp;
   endfunction

   // level msb set means fire above and clear means fire below
   function automatic logic trigger_decision(input logic ready, input logic active,
                                             input logic arm_q, input adc_sample_t sample,
                                             input adc_sample_t level);
      logic hit;
      hit = level[adc_width-1] ? (sample > level) : (sample < level);
      return ready && active && arm_q && hit;
   endfunction

   function automatic int expected_edges(input int half);
      return window_len / (2 * half);
   endfunction

   task automatic compare_values(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timed out at %0t ns while waiting for %s", $time, what);
      $display("** FAIL **");
      $finish;
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (reset) begin
         @(negedge clk_usb);
         n++;
         if (n > 50) report_timeout("reset release");
      end
   endtask

   task automatic wait_windows(input int count);
      int n;
      for (int w = 0; w < count; w++) begin
         n = 0;
         do begin
            @(negedge clk_usb);
            n++;
            if (n > 2 * window_len) report_timeout("a window pulse");
         end while (!freq_measure_o);
         @(negedge clk_usb);  // latched count visible from here
      end
   endtask

   task automatic wait_change();
      int n;
      n = 0;
      while (!extclk_change_o) begin
         @(negedge clk_usb);
         n++;
         if (n > 3 * window_len + 8) report_timeout("the extclk change flag");
      end
   endtask

   task automatic check_frequency(input int half);
      int exp;
      int diff;
      exp  = expected_edges(half);
      diff = int'(extclk_frequency_o) - exp;
      // within one edge of the ideal count is a match
      compare_values("extclk frequency", (diff >= -1 && diff <= 1) ? exp : diff + exp, exp);
   endtask

   task automatic drive_random_cycle();
      @(negedge clk_usb);
      adc_data_i       = adc_sample_t'(take_bits(adc_width));
      armed_i          = 1'(take_bits(1));
      capture_active_i = 1'(take_bits(1));
   endtask

   // target clock toggles every ext_half cycles
   always @(negedge clk_usb) begin
      if (ext_half != 0) begin
         if (ext_cnt >= ext_half - 1) begin
            ext_cnt   <= 0;
            ext_clk_i <= !ext_clk_i;
         end
         else begin
            ext_cnt <= ext_cnt + 1;
         end
      end
   end

   // compare process just after each sampling edge
   always @(posedge clk_usb) begin
      #1;
      if (reset) begin
         compare_values("trigger during reset", trigger_adc_o, 0);
         compare_values("window during reset", freq_measure_o, 0);
         cnt_m       = '0;
         ready_m     = 1'b1;
         arm_q_m     = 1'b0;
         pre_valid   = 1'b0;
         out_valid   = 1'b0;
         window_seen = 1'b0;
         window_gap  = 0;
      end
      else begin
         fire_m = out_valid && trigger_decision(ready_m, adc_trigger_active_i, arm_q_m,
                                                exp_out, trigger_level_i);
         compare_values("trigger pulse", trigger_adc_o, fire_m);
         if (fire_m) begin
            ready_m = 1'b0;
         end
         else if (armed_and_ready_i && !arm_q_m) begin
            ready_m = 1'b1;  // rising arm edge
         end
         arm_q_m   = armed_and_ready_i;
         last_ctr  = out_valid && out_ctr;
         exp_out   = exp_pre;
         out_ctr   = pre_ctr;
         out_valid = pre_valid;
         exp_pre   = source_sample(data_source_select_i, adc_data_i, cnt_m);
         pre_ctr   = !data_source_select_i;
         pre_valid = 1'b1;
         cnt_m     = cnt_m + 1'b1;
         if (out_valid) compare_values("sample path", adc_data_o, exp_out);
         if (out_valid && out_ctr && last_ctr) begin
            compare_values("counter step", adc_data_o, adc_sample_t'(last_obs + 1'b1));
         end
         last_obs = adc_data_o;
         window_gap++;
         if (freq_measure_o) begin
            if (window_seen) compare_values("window spacing", window_gap, window_len);
            window_seen = 1'b1;
            window_gap  = 0;
         end
      end
      if (trigger_adc_o) pulse_count++;
      if (extclk_change_o) begin
         compare_values("led armed shows flash", led_armed_o, flash_pattern_o);
         compare_values("led capture shows flash", led_capture_o, flash_pattern_o);
      end
      else if (led_select_i == LED_STATUS) begin
         compare_values("led armed", led_armed_o, armed_i);
         compare_values("led capture", led_capture_o, capture_active_i);
      end
   end

   initial begin
      int first_pulses;
      int arm_pulses;
      int ones;
      adc_data_i               = '0;
      data_source_select_i     = 1'b1;
      trigger_level_i          = '0;
      adc_trigger_active_i     = 1'b0;
      armed_and_ready_i        = 1'b0;
      armed_i                  = 1'b0;
      capture_active_i         = 1'b0;
      extclk_monitor_disable_i = 1'b1;
      extclk_limit_i           = 32'd4;
      led_select_i             = LED_STATUS;
      gain_i                   = '0;
      wait_reset_release();

      // ADC words then the test ramp
      repeat (40) drive_random_cycle();
      @(negedge clk_usb);
      data_source_select_i = 1'b0;
      repeat (40) drive_random_cycle();
      @(negedge clk_usb);
      data_source_select_i = 1'b1;

      // level msb alternates between armings
      adc_trigger_active_i = 1'b1;
      first_pulses = pulse_count;
      for (int a = 0; a < 8; a++) begin
         @(negedge clk_usb);
         trigger_level_i   = {a[0], 11'(take_bits(11))};
         armed_and_ready_i = 1'b1;
         arm_pulses        = pulse_count;
         repeat (30) drive_random_cycle();
         @(negedge clk_usb);
         armed_and_ready_i = 1'b0;
         repeat (4) drive_random_cycle();
         compare_values("at most one pulse per arming", (pulse_count - arm_pulses) <= 1, 1);
      end
      compare_values("trigger fired at all", (pulse_count - first_pulses) > 0, 1);
      adc_trigger_active_i = 1'b0;

      ext_half = 4;
      wait_windows(2);
      check_frequency(4);
      ext_half = 8;
      wait_windows(2);
      check_frequency(8);

      // change flag with a limit of 4 edges per window
      extclk_monitor_disable_i = 1'b0;
      wait_windows(2);
      compare_values("change flag, steady clock", extclk_change_o, 0);
      ext_half = 7;
      wait_windows(3);
      compare_values("change flag, small step", extclk_change_o, 0);
      led_select_i = LED_TIMERS;  // flash override must beat the selector
      ext_half = 2;
      wait_change();
      wait_windows(2);
      compare_values("change flag sticky", extclk_change_o, 1);
      extclk_monitor_disable_i = 1'b1;
      repeat (2) @(negedge clk_usb);
      compare_values("change flag after disable", extclk_change_o, 0);
      led_select_i = LED_STATUS;

      // pwm duty over one full accumulator turn
      for (int g = 0; g < 4; g++) begin
         @(negedge clk_usb);
         gain_i = gain_t'(take_bits(8));
         repeat (8) @(negedge clk_usb);
         ones = 0;
         repeat (256) begin
            @(negedge clk_usb);
            ones += amp_gain_o;
         end
         compare_values("pwm high cycles", ones, gain_i);
      end

      repeat (4) @(negedge clk_usb);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end
      else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
hdl/adc_pkg.sv
hdl/monitor_pkg.sv
hdl/adc_sample_source.sv
hdl/adc_level_trigger.sv
hdl/extclk_monitor.sv
hdl/status_indicators.sv
hdl/openadc_front.sv
bench/tb_clock_gen.sv
bench/openadc_front_tb.sv

//--- Makefile
# Verilator build and run for the clk_usb front end

VERILATOR ?= verilator
TOP       ?= openadc_front_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= \*\* PASS \*\*

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
